// File: Makefile
BUILD := obj_dir
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f acq_link_top.f --top-module tb_acq_link_top -Mdir $(BUILD)

run: build
	./$(BUILD)/Vtb_acq_link_top +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then exit 1; fi
	@grep -qF "*** TEST PASSED ***" $(LOG)

lint:
	verilator --lint-only -Ihw --top-module acq_link_top hw/acq_link_pkg.sv \
		hw/acq_sequencer.sv hw/frame_scheduler.sv hw/link_interface.sv \
		hw/serial_tx.sv hw/acq_link_top.sv

clean:
	rm -rf $(BUILD) $(LOG)

// File: acq_link_top.f
+incdir+hw
hw/acq_link_pkg.sv
hw/acq_sequencer.sv
hw/frame_scheduler.sv
hw/link_interface.sv
hw/serial_tx.sv
hw/acq_link_top.sv
test/tb_clock_gen.sv
test/acq_link_assertions.sv
test/acq_link_checker.sv
test/tb_acq_link_top.sv

// File: hw/acq_link_pkg.sv
package acq_link_pkg;

	// acquisition sequencer, one pass per sample
	typedef enum logic [2:0] {
		// enable the analog multiplexer
		SEQ_MUX_ON    = 3'b000,
		// one cycle for the multiplexer to settle
		SEQ_SETTLE    = 3'b001,
		// raise soc towards the converter
		SEQ_START     = 3'b010,
		// converter busy while eoc is high
		SEQ_WAIT_CONV = 3'b011,
		// drop load strobe, step the channel
		SEQ_LATCH     = 3'b100,
		// raise send_data towards the scheduler
		SEQ_REQUEST   = 3'b101,
		// wait for the scheduler to take the sample
		SEQ_REQ_WAIT  = 3'b110,
		// wait for the scheduler to finish both bytes
		SEQ_WAIT_RDY  = 3'b111
	} seq_state_t;

	// frame scheduler, two byte transfers per sample
	typedef enum logic [1:0] {
		SCHED_IDLE         = 2'b00,
		SCHED_SHOT         = 2'b01,
		SCHED_WAIT_CONFIRM = 2'b10,
		// guard cycle so a stale send_data is not taken twice
		SCHED_DONE         = 2'b11
	} sched_state_t;

	// link interface controller
	typedef enum logic [1:0] {
		LINK_IDLE     = 2'b00,
		LINK_LOAD     = 2'b01,
		LINK_SEND     = 2'b10,
		LINK_WAIT_END = 2'b11
	} link_state_t;

	// serial frame position, data bits carry their own index
	typedef enum logic [1:0] {
		TX_START = 2'b00,
		TX_DATA  = 2'b01,
		TX_STOP  = 2'b10
	} tx_bit_t;

endpackage

// File: hw/acq_link_settings.svh
`ifndef ACQ_LINK_SETTINGS_SVH
`define ACQ_LINK_SETTINGS_SVH

// clock cycles per serial bit
// 16 keeps simulation short, the real link uses 104
`define ACQ_BIT_TICKS 16

// width of one serial byte
`define ACQ_BYTE_W 8

// number of multiplexer channels, counter wraps after the last one
`define ACQ_CHANNELS 8

`endif

// File: hw/acq_link_top.sv
`timescale 1ns/100ps
`include "acq_link_settings.svh"

module acq_link_top (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   eoc,
	input  logic                   dsr,
	input  logic [`ACQ_BYTE_W-1:0] data_in,
	output logic                   soc,
	output logic                   load_dato,
	output logic                   mux_en,
	output logic                   add_mpx2,
	output logic [3:0]             canale,
	output logic                   error,
	output logic                   data_out
);

	// sequencer and scheduler handshake
	logic send_data;
	logic rdy;
	// scheduler and link interface
	logic shot;
	logic confirm;
	// link interface and transmitter
	logic send_en;
	logic tx_end;
	logic [`ACQ_BYTE_W-1:0] tx_byte;

	acq_sequencer u_sequencer (
		.clock     (clock),
		.rst_n     (rst_n),
		.eoc       (eoc),
		.rdy       (rdy),
		.soc       (soc),
		.load_dato (load_dato),
		.mux_en    (mux_en),
		.canale    (canale),
		.send_data (send_data)
	);

	frame_scheduler u_scheduler (
		.clock     (clock),
		.rst_n     (rst_n),
		.send_data (send_data),
		.confirm   (confirm),
		.rdy       (rdy),
		.shot      (shot),
		.add_mpx2  (add_mpx2)
	);

	link_interface u_link (
		.clock   (clock),
		.rst_n   (rst_n),
		.shot    (shot),
		.tx_end  (tx_end),
		.dsr     (dsr),
		.data_in (data_in),
		.confirm (confirm),
		.send_en (send_en),
		.tx_byte (tx_byte),
		.error   (error)
	);

	serial_tx u_tx (
		.clock    (clock),
		.rst_n    (rst_n),
		.send_en  (send_en),
		.tx_byte  (tx_byte),
		.tx_end   (tx_end),
		.data_out (data_out)
	);

endmodule

// File: hw/acq_sequencer.sv
`timescale 1ns/100ps
`include "acq_link_settings.svh"

module acq_sequencer import acq_link_pkg::*; (
	input  logic       clock,
	input  logic       rst_n,
	input  logic       eoc,
	input  logic       rdy,
	output logic       soc,
	output logic       load_dato,
	output logic       mux_en,
	output logic [3:0] canale,
	output logic       send_data
);

	// last channel number before wrapping back to 0
	localparam logic [3:0] LAST_CHAN = 4'(`ACQ_CHANNELS - 1);

	seq_state_t state;
	// channel counter, first sample after reset reports channel 1
	logic [3:0] chan_cnt;

	assign canale = chan_cnt;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state     <= SEQ_MUX_ON;
			soc       <= 1'b0;
			load_dato <= 1'b0;
			mux_en    <= 1'b0;
			send_data <= 1'b0;
			chan_cnt  <= 4'd0;
		end else begin
			case (state)
				SEQ_MUX_ON: begin
					mux_en <= 1'b1;
					state  <= SEQ_SETTLE;
				end
				SEQ_SETTLE: begin
					state <= SEQ_START;
				end
				SEQ_START: begin
					// soc lands two cycles after mux_en
					soc   <= 1'b1;
					state <= SEQ_WAIT_CONV;
				end
				SEQ_WAIT_CONV: begin
					// converter busy, keep soc up and wait
					if (!eoc) begin
						load_dato <= 1'b1;
						mux_en    <= 1'b0;
						state     <= SEQ_LATCH;
					end
				end
				SEQ_LATCH: begin
					load_dato <= 1'b0;
					soc       <= 1'b0;
					// step through 1..7 then back to 0
					if (chan_cnt == LAST_CHAN) begin
						chan_cnt <= 4'd0;
					end else begin
						chan_cnt <= chan_cnt + 4'd1;
					end
					state <= SEQ_REQUEST;
				end
				SEQ_REQUEST: begin
					send_data <= 1'b1;
					state     <= SEQ_REQ_WAIT;
				end
				SEQ_REQ_WAIT: begin
					// scheduler has taken the sample once rdy is up
					if (rdy) begin
						state <= SEQ_WAIT_RDY;
					end
				end
				SEQ_WAIT_RDY: begin
					// rdy low means both bytes are out
					if (!rdy) begin
						send_data <= 1'b0;
						state     <= SEQ_MUX_ON;
					end
				end
				default: begin
					state <= SEQ_MUX_ON;
				end
			endcase
		end
	end

endmodule

// File: hw/frame_scheduler.sv
`timescale 1ns/100ps

module frame_scheduler import acq_link_pkg::*; (
	input  logic clock,
	input  logic rst_n,
	input  logic send_data,
	input  logic confirm,
	output logic rdy,
	output logic shot,
	output logic add_mpx2
);

	sched_state_t state;
	// set between first and second byte of a sample
	logic second_byte;

	// second multiplexer input selected for the second byte
	assign add_mpx2 = second_byte;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state       <= SCHED_IDLE;
			rdy         <= 1'b0;
			shot        <= 1'b0;
			second_byte <= 1'b0;
		end else begin
			case (state)
				SCHED_IDLE: begin
					if (send_data) begin
						rdy   <= 1'b1;
						state <= SCHED_SHOT;
					end
				end
				SCHED_SHOT: begin
					// one shot per byte
					shot  <= 1'b1;
					state <= SCHED_WAIT_CONFIRM;
				end
				SCHED_WAIT_CONFIRM: begin
					shot <= 1'b0;
					if (confirm) begin
						if (!second_byte) begin
							// first byte out, switch mux and go again
							second_byte <= 1'b1;
							state       <= SCHED_SHOT;
						end else begin
							// pair complete, hand the sample back
							second_byte <= 1'b0;
							rdy         <= 1'b0;
							state       <= SCHED_DONE;
						end
					end
				end
				SCHED_DONE: begin
					// sequencer still holds send_data this cycle
					state <= SCHED_IDLE;
				end
				default: begin
					state <= SCHED_IDLE;
				end
			endcase
		end
	end

endmodule

// File: hw/link_interface.sv
`timescale 1ns/100ps
`include "acq_link_settings.svh"

module link_interface import acq_link_pkg::*; (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   shot,
	input  logic                   tx_end,
	input  logic                   dsr,
	input  logic [`ACQ_BYTE_W-1:0] data_in,
	output logic                   confirm,
	output logic                   send_en,
	output logic [`ACQ_BYTE_W-1:0] tx_byte,
	output logic                   error
);

	link_state_t state;
	// buffer holds a byte not yet sent
	logic tre;
	logic load;
	logic send;

	assign load = (state == LINK_LOAD);
	assign send = (state == LINK_SEND);

	// transmit buffer, only written when empty
	always_ff @(posedge clock) begin
		if (load && !tre) begin
			tx_byte <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state   <= LINK_IDLE;
			tre     <= 1'b0;
			send_en <= 1'b0;
			confirm <= 1'b0;
			error   <= 1'b0;
		end else begin
			// confirm is a single-cycle pulse
			confirm <= 1'b0;
			case (state)
				LINK_IDLE: begin
					if (shot) begin
						state <= LINK_LOAD;
					end
				end
				LINK_LOAD: begin
					if (!tre) begin
						tre   <= 1'b1;
						error <= 1'b0;
					end else begin
						// overrun, old byte stays in the buffer
						error <= 1'b1;
					end
					state <= LINK_SEND;
				end
				LINK_SEND: begin
					// receiver not ready, flag and retry next cycle
					if (dsr) begin
						send_en <= 1'b1;
						error   <= 1'b0;
						state   <= LINK_WAIT_END;
					end else begin
						error <= 1'b1;
					end
				end
				LINK_WAIT_END: begin
					if (tx_end) begin
						send_en <= 1'b0;
						tre     <= 1'b0;
						confirm <= 1'b1;
						state   <= LINK_IDLE;
					end
				end
				default: begin
					state <= LINK_IDLE;
				end
			endcase
		end
	end

endmodule

// File: hw/serial_tx.sv
`timescale 1ns/100ps
`include "acq_link_settings.svh"

module serial_tx import acq_link_pkg::*; (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   send_en,
	input  logic [`ACQ_BYTE_W-1:0] tx_byte,
	output logic                   tx_end,
	output logic                   data_out
);

	localparam int TICK_W = $clog2(`ACQ_BIT_TICKS);
	localparam int IDX_W = $clog2(`ACQ_BYTE_W);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`ACQ_BIT_TICKS - 1);
	// msb goes out first
	localparam logic [IDX_W-1:0] IDX_MSB = IDX_W'(`ACQ_BYTE_W - 1);

	tx_bit_t pos;
	logic [TICK_W-1:0] tick;
	logic [IDX_W-1:0] bit_idx;
	logic bit_done;

	// last cycle of the current bit period
	assign bit_done = (tick == TICK_LAST);
	assign tx_end = send_en && (pos == TX_STOP) && bit_done;

	// line idles high
	always_comb begin
		if (!send_en) begin
			data_out = 1'b1;
		end else begin
			case (pos)
				TX_START: data_out = 1'b0;
				TX_DATA:  data_out = tx_byte[bit_idx];
				default:  data_out = 1'b1;
			endcase
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pos     <= TX_START;
			tick    <= '0;
			bit_idx <= IDX_MSB;
		end else if (!send_en) begin
			// hold at frame start until a byte is due
			pos     <= TX_START;
			tick    <= '0;
			bit_idx <= IDX_MSB;
		end else if (!bit_done) begin
			tick <= tick + 1'b1;
		end else begin
			tick <= '0;
			case (pos)
				TX_START: begin
					pos     <= TX_DATA;
					bit_idx <= IDX_MSB;
				end
				TX_DATA: begin
					if (bit_idx == '0) begin
						pos <= TX_STOP;
					end else begin
						bit_idx <= bit_idx - 1'b1;
					end
				end
				default: begin
					// stop bit done, ready for the next frame
					pos <= TX_START;
				end
			endcase
		end
	end

endmodule

// File: test/acq_link_assertions.sv
`timescale 1ns/100ps

module acq_link_assertions (
	input logic clock,
	input logic rst_n,
	input logic load,
	input logic send,
	input logic error,
	input logic confirm,
	input logic tx_end,
	input logic tre,
	input logic send_en
);

	// failures seen so far, read by the testbench at the end
	int fails = 0;

	// no new load or send while a frame is still going out
	load_send_excl: assert property (@(posedge clock) disable iff (!rst_n)
		!((load || send) && send_en))
	else begin
		fails++;
		$error("link load or send active while a frame is going out");
	end

	// a confirmed byte went out cleanly
	error_confirm_excl: assert property (@(posedge clock) disable iff (!rst_n)
		!(error && confirm))
	else begin
		fails++;
		$error("link error and confirm high together");
	end

	// end of frame frees the buffer and parks the transmitter at start
	tx_end_release: assert property (@(posedge clock) disable iff (!rst_n)
		tx_end |=> (confirm && !send_en && !tre))
	else begin
		fails++;
		$error("tx_end not followed by confirm with buffer and send_en cleared");
	end

	// a frame under way always has a full buffer behind it
	send_needs_buffer: assert property (@(posedge clock) disable iff (!rst_n)
		send_en |-> tre)
	else begin
		fails++;
		$error("send_en high while the transmit buffer is empty");
	end

endmodule

// File: test/acq_link_checker.sv
`timescale 1ns/100ps
`include "acq_link_settings.svh"

module acq_link_checker (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   eoc,
	input  logic                   dsr,
	input  logic                   soc,
	input  logic                   load_dato,
	input  logic                   mux_en,
	input  logic                   add_mpx2,
	input  logic [3:0]             canale,
	input  logic                   error,
	input  logic                   data_out,
	input  logic [`ACQ_BYTE_W-1:0] exp_a,
	input  logic [`ACQ_BYTE_W-1:0] exp_b,
	input  logic                   exp_stall,
	output int                     errors,
	output int                     frames
);

	// bit centre, counted in negedges from the first low sample
	localparam int HALF = `ACQ_BIT_TICKS / 2;
	localparam logic [3:0] LAST_CHAN = 4'(`ACQ_CHANNELS - 1);

	logic in_frame;
	int cnt;
	logic [`ACQ_BYTE_W-1:0] shift;
	// 0 while byte A is on the line, 1 for byte B
	logic frame_no;
	int loads;
	logic err_seen;
	logic [3:0] model_chan;
	logic soc_q;
	logic mux_q;

	task automatic show_mismatch(input string name, input int exp_val, input int got_val);
		$display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp_val, got_val);
		errors++;
	endtask

	task automatic log_failure(input string what);
		$display("Error at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic check_frame_start();
		// send only starts once dsr is back, so error is clear again
		if (error !== 1'b0) begin
			show_mismatch("error", 0, int'(error));
		end
		if (!frame_no) begin
			if (canale !== model_chan) begin
				show_mismatch("canale", int'(model_chan), int'(canale));
			end
			if (exp_stall && !err_seen) begin
				log_failure("error was not raised while dsr held the send back");
			end
			if (!exp_stall && err_seen) begin
				log_failure("error was raised although dsr was high at the send");
			end
		end
	endtask

	task automatic sample_bit();
		int bit_no;
		logic [`ACQ_BYTE_W-1:0] expected;
		bit_no = cnt / `ACQ_BIT_TICKS;
		expected = frame_no ? exp_b : exp_a;
		if ((cnt % `ACQ_BIT_TICKS) == HALF) begin
			// mux select must match the byte being sent
			if (add_mpx2 !== frame_no) begin
				show_mismatch("add_mpx2", int'(frame_no), int'(add_mpx2));
			end
			if (bit_no == 0) begin
				if (data_out !== 1'b0) begin
					log_failure("start bit of a frame is not low on data_out");
				end
			end else if (bit_no <= `ACQ_BYTE_W) begin
				// msb arrives first
				shift = {shift[`ACQ_BYTE_W-2:0], data_out};
			end else begin
				if (data_out !== 1'b1) begin
					log_failure("stop bit of a frame is not high on data_out");
				end
				if (shift !== expected) begin
					show_mismatch("data_out", int'(expected), int'(shift));
				end
				if (frame_no && loads != 1) begin
					log_failure($sformatf("load_dato pulsed %0d times in one sample", loads));
				end
				frames++;
				frame_no = !frame_no;
				in_frame = 1'b0;
			end
		end
		cnt++;
	endtask

	// everything is settled at the falling edge
	always @(negedge clock) begin
		if (!rst_n) begin
			errors     = 0;
			frames     = 0;
			in_frame   = 1'b0;
			cnt        = 0;
			shift      = '0;
			frame_no   = 1'b0;
			loads      = 0;
			err_seen   = 1'b0;
			model_chan = 4'd0;
			soc_q      = 1'b0;
			mux_q      = 1'b0;
		end else begin
			// new conversion, model channel steps 1..7 then 0
			if (soc && !soc_q) begin
				model_chan = (model_chan == LAST_CHAN) ? 4'd0 : model_chan + 4'd1;
				loads = 0;
				err_seen = 1'b0;
				if (add_mpx2 !== 1'b0) begin
					show_mismatch("add_mpx2", 0, int'(add_mpx2));
				end
			end
			if (load_dato) begin
				loads++;
				if (eoc) begin
					log_failure("load_dato pulsed while eoc was still high");
				end
				if (!soc) begin
					show_mismatch("soc", 1, int'(soc));
				end
				if (mux_en || !mux_q) begin
					log_failure("mux_en did not fall together with load_dato");
				end
			end
			// receiver not ready, line stays idle
			if (!dsr && !data_out) begin
				log_failure("data_out left the idle level while dsr was low");
			end
			if (in_frame) begin
				sample_bit();
			end else if (!data_out) begin
				in_frame = 1'b1;
				cnt = 1;
				check_frame_start();
			end
			if (error) begin
				err_seen = 1'b1;
			end
			soc_q = soc;
			mux_q = mux_en;
		end
	end

endmodule

// File: test/acq_link_patterns.txt
// one word per sample: byte_a byte_b eoc_busy dsr_low (hex, byte each)
// eoc_busy and dsr_low are counted in clock cycles
a5_3c_04_00
81_7e_00_02
ff_00_09_0c
00_ff_02_19
5a_c3_01_00
12_34_0f_00
80_01_03_28
7f_fe_00_01
c6_39_06_0e
01_80_02_00
e7_18_0a_14
96_69_05_00

// File: test/tb_acq_link_top.sv
`timescale 1ns/100ps
`include "acq_link_settings.svh"

module tb_acq_link_top;

	localparam int NUM_PATTERNS = 12;
	localparam int CLK_NS = 8;
	// load, send_data, rdy, shot, link load, then the send cycle samples dsr
	localparam int SEND_AFTER_LOAD = 7;

	logic clock;
	logic rst_n;
	logic eoc;
	logic dsr;
	logic [`ACQ_BYTE_W-1:0] data_in;
	logic soc;
	logic load_dato;
	logic mux_en;
	logic add_mpx2;
	logic [3:0] canale;
	logic error;
	logic data_out;

	// byte_a, byte_b, eoc busy cycles, dsr low cycles
	logic [31:0] patterns [NUM_PATTERNS];
	logic [`ACQ_BYTE_W-1:0] exp_a;
	logic [`ACQ_BYTE_W-1:0] exp_b;
	logic exp_stall;
	int check_errors;
	int frames;
	int seed;
	longint limit_ns;
	int cur;
	int next_idx;
	int busy_left;
	int dsr_left;
	logic soc_q;
	logic load_q;

	tb_clock_gen u_clock_gen (
		.clock (clock),
		.rst_n (rst_n)
	);

	acq_link_top u_dut (
		.clock     (clock),
		.rst_n     (rst_n),
		.eoc       (eoc),
		.dsr       (dsr),
		.data_in   (data_in),
		.soc       (soc),
		.load_dato (load_dato),
		.mux_en    (mux_en),
		.add_mpx2  (add_mpx2),
		.canale    (canale),
		.error     (error),
		.data_out  (data_out)
	);

	acq_link_checker u_checker (
		.clock     (clock),
		.rst_n     (rst_n),
		.eoc       (eoc),
		.dsr       (dsr),
		.soc       (soc),
		.load_dato (load_dato),
		.mux_en    (mux_en),
		.add_mpx2  (add_mpx2),
		.canale    (canale),
		.error     (error),
		.data_out  (data_out),
		.exp_a     (exp_a),
		.exp_b     (exp_b),
		.exp_stall (exp_stall),
		.errors    (check_errors),
		.frames    (frames)
	);

	bind link_interface acq_link_assertions u_assert (
		.clock   (clock),
		.rst_n   (rst_n),
		.load    (load),
		.send    (send),
		.error   (error),
		.confirm (confirm),
		.tx_end  (tx_end),
		.tre     (tre),
		.send_en (send_en)
	);

	// converter model, busy for the pattern's cycles plus a little noise
	task automatic drive_converter();
		if (soc && !soc_q) begin
			if (next_idx < NUM_PATTERNS) begin
				cur = next_idx;
				next_idx++;
				exp_a = patterns[cur][31:24];
				exp_b = patterns[cur][23:16];
				exp_stall = int'(patterns[cur][7:0]) >= SEND_AFTER_LOAD;
				busy_left = int'(patterns[cur][15:8]) + int'($unsigned($random(seed)) % 4);
			end else begin
				// out of samples, converter stays busy
				busy_left = -1;
			end
		end else if (busy_left > 0) begin
			busy_left--;
		end
		eoc = (busy_left != 0);
		soc_q = soc;
	endtask

	// receiver drops dsr after each latched sample
	task automatic update_dsr();
		if (load_dato && !load_q) begin
			dsr_left = int'(patterns[cur][7:0]);
		end else if (dsr_left > 0) begin
			dsr_left--;
		end
		dsr = (dsr_left == 0);
		load_q = load_dato;
	endtask

	initial begin
		int max_busy;
		int max_dsr;
		eoc = 1'b0;
		dsr = 1'b1;
		data_in = '0;
		exp_a = '0;
		exp_b = '0;
		exp_stall = 1'b0;
		cur = 0;
		next_idx = 0;
		busy_left = 0;
		dsr_left = 0;
		soc_q = 1'b0;
		load_q = 1'b0;
		limit_ns = 0;
		seed = 32'h388db7a8;
		max_busy = 0;
		max_dsr = 0;
		$readmemh("test/acq_link_patterns.txt", patterns);
		for (int i = 0; i < NUM_PATTERNS; i++) begin
			if (int'(patterns[i][15:8]) > max_busy) begin
				max_busy = int'(patterns[i][15:8]);
			end
			if (int'(patterns[i][7:0]) > max_dsr) begin
				max_dsr = int'(patterns[i][7:0]);
			end
		end
		// two frames of ten bits per sample, random busy adds up to 3
		limit_ns = longint'(NUM_PATTERNS) * longint'(CLK_NS) *
			longint'(2 * 10 * `ACQ_BIT_TICKS + max_busy + 3 + max_dsr + 20);
		@(posedge rst_n);
		forever begin
			@(posedge clock);
			#1;
			drive_converter();
			update_dsr();
			// second mux input while add_mpx2 is high
			data_in = add_mpx2 ? exp_b : exp_a;
		end
	end

	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("Timeout: %0d of %0d frames received", frames, 2 * NUM_PATTERNS);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int fails;
		wait (rst_n === 1'b1);
		wait (frames == 2 * NUM_PATTERNS);
		repeat (4) @(posedge clock);
		fails = u_dut.u_link.u_assert.fails;
		$display("Frames %0d, check errors %0d, assertion failures %0d",
			frames, check_errors, fails);
		if (check_errors == 0 && fails == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clock,
	output logic rst_n
);

	// 8 ns period
	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// reset held for five rising edges, released just after the fifth
	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clock);
		#1;
		rst_n = 1'b1;
	end

endmodule
